// File: list.f
+incdir+common
common/io_pkg.sv
hw/io_decode.sv
timer/io_timer.sv
hw/io_watchdog.sv
hw/io_irq_ctrl.sv
hw/io_gpio.sv
hw/io_read_mux.sv
hw/io_system.sv
verif/io_system_chk.sv
verif/io_system_tb.sv

// File: Makefile
# Verilator flow for the I/O subsystem testbench.

VERILATOR ?= verilator
TOP ?= io_system_tb
FILE_LIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
FAIL_MSG ?= sim failed
PASS_MSG ?= sim passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/io_system_tb.sv
`include "io_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module io_system_tb;
	import io_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 8;
	localparam int RUN_CYCLES = 5000;
	localparam int TIMEOUT_NS = (RST_CYCLES + RUN_CYCLES + 50) * CLK_PERIOD;

	// Bank word addresses of the register map.
	localparam waddr_t KICK = waddr_t'(`IO_KICK_ADDR >> 1);
	localparam waddr_t IRQ_EN = waddr_t'(`IO_IRQ_BASE >> 1);
	localparam waddr_t IRQ_ACT = waddr_t'((`IO_IRQ_BASE + 16'd2) >> 1);
	localparam waddr_t T_CFG = waddr_t'(`IO_TIMER_BASE >> 1);
	localparam waddr_t T_CNT = waddr_t'((`IO_TIMER_BASE + 16'd2) >> 1);
	localparam waddr_t T_RLD = waddr_t'((`IO_TIMER_BASE + 16'd4) >> 1);
	localparam waddr_t T_CMP = waddr_t'((`IO_TIMER_BASE + 16'd6) >> 1);
	localparam waddr_t W_CFG = waddr_t'(`IO_WDOG_BASE >> 1);
	localparam waddr_t W_CNT = waddr_t'((`IO_WDOG_BASE + 16'd2) >> 1);
	localparam waddr_t W_RLD = waddr_t'((`IO_WDOG_BASE + 16'd4) >> 1);
	localparam waddr_t G_DDR = waddr_t'(`IO_GPIO_BASE >> 1);
	localparam waddr_t G_ODR = waddr_t'((`IO_GPIO_BASE + 16'd2) >> 1);
	localparam waddr_t G_IDR = waddr_t'((`IO_GPIO_BASE + 16'd4) >> 1);

	logic clk;
	logic rst;
	bus_wr_t wr_even;
	bus_wr_t wr_odd;
	waddr_t rd_addr_even;
	waddr_t rd_addr_odd;
	byte_t rd_data_even;
	byte_t rd_data_odd;
	logic trap;
	logic interrupt;
	logic cpu_reset;
	byte_t pins_in;
	byte_t pins_out;
	byte_t pins_oe;

	timer_regs_t m_timer;
	wdog_regs_t m_wdog;
	gpio_regs_t m_gpio;
	irq_vec_t m_irq_en;
	irq_vec_t m_irq_act;
	logic m_interrupt;
	logic m_cpu_reset;
	byte_t m_rd_even;
	byte_t m_rd_odd;
	logic [31:0] seed_state;
	waddr_t addr_table [16];

	io_system UUT (.clk(clk), .rst(rst), .wr_even(wr_even), .wr_odd(wr_odd),
		.rd_addr_even(rd_addr_even), .rd_addr_odd(rd_addr_odd),
		.rd_data_even(rd_data_even), .rd_data_odd(rd_data_odd), .trap(trap),
		.interrupt(interrupt), .cpu_reset(cpu_reset), .pins_in(pins_in),
		.pins_out(pins_out), .pins_oe(pins_oe));

	function automatic logic [31:0] next_rand();
		seed_state = seed_state * 32'd1664525 + 32'd1013904223;
		return seed_state;
	endfunction

	function automatic waddr_t pick_addr();
		logic [31:0] r;
		r = next_rand();
		return addr_table[r[27:24]];
	endfunction

	function automatic logic hit(bus_wr_t port, waddr_t a);
		return port.en && (port.addr == a);
	endfunction

	function automatic word_t merge_word(word_t old, logic lo_we, logic hi_we, word_t wd);
		word_t res;
		res = old;
		if (lo_we)
			res[7:0] = wd[7:0];
		if (hi_we)
			res[15:8] = wd[15:8];
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Reference model
	function automatic byte_t even_reg(waddr_t a);
		case (a)
			IRQ_EN: return byte_t'(m_irq_en);
			IRQ_ACT: return byte_t'(m_irq_act);
			T_CFG: return m_timer.cfg;
			T_CNT: return m_timer.cnt[7:0];
			T_RLD: return m_timer.rld[7:0];
			T_CMP: return m_timer.cmp[7:0];
			W_CFG: return m_wdog.cfg;
			W_CNT: return m_wdog.cnt[7:0];
			W_RLD: return m_wdog.rld[7:0];
			G_DDR: return m_gpio.ddr;
			G_ODR: return m_gpio.odr;
			G_IDR: return m_gpio.idr;
			default: return 8'h00;
		endcase
	endfunction

	function automatic byte_t odd_reg(waddr_t a);
		case (a)
			T_CNT: return m_timer.cnt[15:8];
			T_RLD: return m_timer.rld[15:8];
			T_CMP: return m_timer.cmp[15:8];
			W_CNT: return m_wdog.cnt[15:8];
			W_RLD: return m_wdog.rld[15:8];
			default: return 8'h00;
		endcase
	endfunction

	// One clock edge of the whole subsystem, from the inputs seen at that edge.
	task automatic step_model();
		word_t wd;
		logic ovf;
		logic cmp;
		logic kick;
		logic cnt_wr;
		logic expire;
		wd = {wr_odd.data, wr_even.data};
		if (rst)
		begin
			m_timer = '0;
			m_wdog = '0;
			m_gpio = '0;
			m_irq_en = '0;
			m_irq_act = '0;
			m_interrupt = 1'b0;
			m_cpu_reset = 1'b0;
			m_rd_even = 8'h00;
			m_rd_odd = 8'h00;
		end
		else
		begin
			m_rd_even = hit(wr_even, rd_addr_even) ? wr_even.data : even_reg(rd_addr_even);
			m_rd_odd = hit(wr_odd, rd_addr_odd) ? wr_odd.data : odd_reg(rd_addr_odd);
			m_interrupt = |(m_irq_act & m_irq_en); // Built from the flags before this edge.

			ovf = m_timer.cfg[0] && (m_timer.cnt == 16'hFFFF);
			cmp = m_timer.cfg[0] && (m_timer.cnt == m_timer.cmp);
			if (hit(wr_even, IRQ_ACT))
				m_irq_act = m_irq_act & ~wr_even.data[`IO_NUM_IRQ-1:0];
			m_irq_act = m_irq_act | {cmp, ovf};
			if (hit(wr_even, IRQ_EN))
				m_irq_en = wr_even.data[`IO_NUM_IRQ-1:0];

			if (hit(wr_even, T_CNT) || hit(wr_odd, T_CNT))
				m_timer.cnt = merge_word(m_timer.cnt, hit(wr_even, T_CNT), hit(wr_odd, T_CNT), wd);
			else if (ovf)
				m_timer.cnt = m_timer.rld;
			else if (m_timer.cfg[0])
				m_timer.cnt = m_timer.cnt + 16'd1;
			if (hit(wr_even, T_CFG))
				m_timer.cfg = wr_even.data;
			m_timer.rld = merge_word(m_timer.rld, hit(wr_even, T_RLD), hit(wr_odd, T_RLD), wd);
			m_timer.cmp = merge_word(m_timer.cmp, hit(wr_even, T_CMP), hit(wr_odd, T_CMP), wd);

			kick = hit(wr_even, KICK);
			cnt_wr = hit(wr_even, W_CNT) || hit(wr_odd, W_CNT);
			expire = m_wdog.cfg[0] && (m_wdog.cnt == 16'h0000) && !kick && !cnt_wr;
			if (cnt_wr)
				m_wdog.cnt = merge_word(m_wdog.cnt, hit(wr_even, W_CNT), hit(wr_odd, W_CNT), wd);
			else if (kick || expire)
				m_wdog.cnt = m_wdog.rld;
			else if (m_wdog.cfg[0])
				m_wdog.cnt = m_wdog.cnt - 16'd1;
			m_cpu_reset = expire || trap;
			if (hit(wr_even, W_CFG))
				m_wdog.cfg = wr_even.data;
			m_wdog.rld = merge_word(m_wdog.rld, hit(wr_even, W_RLD), hit(wr_odd, W_RLD), wd);

			if (hit(wr_even, G_DDR))
				m_gpio.ddr = wr_even.data;
			if (hit(wr_even, G_ODR))
				m_gpio.odr = wr_even.data;
			m_gpio.idr = pins_in;
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	task automatic drive_random();
		logic [31:0] r;
		logic [31:0] s;
		bus_wr_t we;
		bus_wr_t wo;
		logic tr;
		r = next_rand();
		s = next_rand();
		we.addr = pick_addr();
		we.data = r[15:8];
		we.en = r[31] | r[30];
		wo.addr = r[29] ? we.addr : pick_addr();
		wo.data = r[23:16];
		wo.en = r[28] | r[27];
		// High bytes near the top keep timer overflows frequent.
		if (wo.addr == T_CNT || wo.addr == T_RLD || wo.addr == T_CMP)
			wo.data = 8'hFF;
		if (wo.addr == W_CNT || wo.addr == W_RLD)
			wo.data = 8'h00; // Short watchdog periods.
		if (we.addr == W_RLD)
			we.data[0] = 1'b1; // A zero reload would hold cpu_reset high.
		// A trap only lands where no expiry pulse can touch it.
		tr = (s[31:27] == 5'd0) && !m_wdog.cfg[0] && !m_cpu_reset;
		if (we.addr == W_CFG && (tr || m_wdog.rld == 16'h0000))
			we.data[0] = 1'b0;
		wr_even <= we;
		wr_odd <= wo;
		rd_addr_even <= s[26] ? we.addr : pick_addr();
		rd_addr_odd <= s[25] ? wo.addr : pick_addr();
		trap <= tr;
		pins_in <= s[7:0];
	endtask

	//////////////////////////////////////////////////
	// Checks
	task automatic abort_run(string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_read(string name, byte_t expected, byte_t actual);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH time=%0t %s expected=%02h actual=%02h",
				$time, name, expected, actual));
	endtask

	task automatic expect_line(string name, logic expected, logic actual);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
				$time, name, expected, actual));
	endtask

	task automatic match_pins(string name, byte_t expected, byte_t actual);
		if (actual !== expected)
			abort_run($sformatf("MISMATCH time=%0t %s expected=%02h actual=%02h",
				$time, name, expected, actual));
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		abort_run($sformatf("Timeout: the run did not end within %0d ns.", TIMEOUT_NS));
	end

	initial
	begin
		rst <= 1'b1;
		wr_even <= '0;
		wr_odd <= '0;
		rd_addr_even <= '0;
		rd_addr_odd <= '0;
		trap <= 1'b0;
		pins_in <= 8'h00;
		seed_state = 32'hff93d8bb;
		addr_table = '{KICK, IRQ_EN, IRQ_ACT, T_CFG, T_CNT, T_RLD, T_CMP, W_CFG,
			W_CNT, W_RLD, G_DDR, G_ODR, G_IDR, 15'h0005, 15'h000B, 15'h7FFF};
		for (int cyc = 0; cyc < RST_CYCLES + RUN_CYCLES; cyc++)
		begin
			@(posedge clk);
			step_model();
			if (cyc == RST_CYCLES - 1)
				rst <= 1'b0;
			if (cyc >= RST_CYCLES - 1)
				drive_random();
			@(negedge clk); // Outputs are settled half a period after the edge.
			check_read("rd_data_even", m_rd_even, rd_data_even);
			check_read("rd_data_odd", m_rd_odd, rd_data_odd);
			expect_line("interrupt", m_interrupt, interrupt);
			expect_line("cpu_reset", m_cpu_reset, cpu_reset);
			match_pins("pins_out", m_gpio.odr, pins_out);
			match_pins("pins_oe", m_gpio.ddr, pins_oe);
			if (UUT.u_chk.pulse_bad || UUT.u_chk.mask_bad || UUT.u_chk.read_bad)
				abort_run("A bound assertion on the DUT failed.");
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/io_system_chk.sv
`timescale 1ns/10ps
`default_nettype none

module io_system_chk
(
	input wire logic clk,
	input wire logic rst,
	input wire logic cpu_reset,
	input wire logic interrupt,
	input wire io_pkg::irq_vec_t irq_enable,
	input wire io_pkg::byte_t rd_data_even,
	input wire io_pkg::byte_t rd_data_odd
);

	logic pulse_bad = 1'b0;
	logic mask_bad = 1'b0;
	logic read_bad = 1'b0;

	// The processor reset is a single-cycle pulse.
	reset_single_pulse: assert property (@(posedge clk) disable iff (rst)
		cpu_reset |=> !cpu_reset)
		else
		begin
			pulse_bad = 1'b1;
			$error("cpu_reset stayed high for two cycles");
		end

	// The interrupt line is registered, so it follows the enable mask one edge late.
	masked_interrupt: assert property (@(posedge clk) disable iff (rst)
		($past(irq_enable) == '0) |-> !interrupt)
		else
		begin
			mask_bad = 1'b1;
			$error("interrupt raised while every source was disabled");
		end

	read_cleared_by_reset: assert property (@(posedge clk)
		rst |=> (rd_data_even == 8'h00 && rd_data_odd == 8'h00))
		else
		begin
			read_bad = 1'b1;
			$error("read data not zero after reset");
		end

endmodule

bind io_system io_system_chk u_chk (.clk(clk), .rst(rst), .cpu_reset(cpu_reset),
	.interrupt(interrupt), .irq_enable(irq_enable), .rd_data_even(rd_data_even),
	.rd_data_odd(rd_data_odd));

`default_nettype wire

// File: hw/io_system.sv
`timescale 1ns/10ps
`default_nettype none

module io_system
(
	input wire logic clk,
	input wire logic rst,
	input wire io_pkg::bus_wr_t wr_even,
	input wire io_pkg::bus_wr_t wr_odd,
	input wire io_pkg::waddr_t rd_addr_even,
	input wire io_pkg::waddr_t rd_addr_odd,
	output io_pkg::byte_t rd_data_even,
	output io_pkg::byte_t rd_data_odd,
	input wire logic trap,
	output logic interrupt,
	output logic cpu_reset,
	input wire io_pkg::byte_t pins_in,
	output io_pkg::byte_t pins_out,
	output io_pkg::byte_t pins_oe
);
	import io_pkg::*;

	reg_wr_t strobes;
	word_t wdata;
	timer_regs_t timer_regs;
	wdog_regs_t wdog_regs;
	gpio_regs_t gpio_regs;
	irq_vec_t sources;
	irq_vec_t irq_enable;
	irq_vec_t irq_active;
	logic ovf_irq;
	logic cmp_irq;

	// Odd byte is the high half of every 16-bit write.
	assign wdata = {wr_odd.data, wr_even.data};
	assign sources = {cmp_irq, ovf_irq}; // Source 0 is overflow, source 1 is compare.

	io_decode u_decode (.wr_even(wr_even), .wr_odd(wr_odd), .strobes(strobes));

	io_timer u_timer (.clk(clk), .rst(rst), .strobes(strobes), .wdata(wdata),
		.regs(timer_regs), .ovf_irq(ovf_irq), .cmp_irq(cmp_irq));

	io_watchdog u_watchdog (.clk(clk), .rst(rst), .strobes(strobes), .wdata(wdata),
		.trap(trap), .regs(wdog_regs), .cpu_reset(cpu_reset));

	io_irq_ctrl u_irq_ctrl (.clk(clk), .rst(rst), .strobes(strobes),
		.wdata_lo(wr_even.data), .sources(sources), .enable(irq_enable),
		.active(irq_active), .interrupt(interrupt));

	io_gpio u_gpio (.clk(clk), .rst(rst), .strobes(strobes), .wdata_lo(wr_even.data),
		.pins_in(pins_in), .pins_out(pins_out), .pins_oe(pins_oe), .regs(gpio_regs));

	io_read_mux u_read_mux (.clk(clk), .rst(rst), .wr_even(wr_even), .wr_odd(wr_odd),
		.rd_addr_even(rd_addr_even), .rd_addr_odd(rd_addr_odd),
		.timer_regs(timer_regs), .wdog_regs(wdog_regs), .gpio_regs(gpio_regs),
		.irq_enable(irq_enable), .irq_active(irq_active),
		.rd_data_even(rd_data_even), .rd_data_odd(rd_data_odd));

endmodule

`default_nettype wire

// File: hw/io_read_mux.sv
`include "io_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module io_read_mux
(
	input wire logic clk,
	input wire logic rst,
	input wire io_pkg::bus_wr_t wr_even,
	input wire io_pkg::bus_wr_t wr_odd,
	input wire io_pkg::waddr_t rd_addr_even,
	input wire io_pkg::waddr_t rd_addr_odd,
	input wire io_pkg::timer_regs_t timer_regs,
	input wire io_pkg::wdog_regs_t wdog_regs,
	input wire io_pkg::gpio_regs_t gpio_regs,
	input wire io_pkg::irq_vec_t irq_enable,
	input wire io_pkg::irq_vec_t irq_active,
	output io_pkg::byte_t rd_data_even,
	output io_pkg::byte_t rd_data_odd
);
	import io_pkg::*;

	byte_t map_even;
	byte_t map_odd;

	function automatic byte_t forward(bus_wr_t wr, waddr_t rd_addr, byte_t mapped);
		return (wr.en && (wr.addr == rd_addr)) ? wr.data : mapped;
	endfunction

	always_comb
	begin
		//////////////////////////////////////////////////
		// Even bank holds every low byte.
		case (rd_addr_even)
			`IO_WADDR(`IO_IRQ_BASE + `IO_IRQ_EN_OFS): map_even = byte_t'(irq_enable);
			`IO_WADDR(`IO_IRQ_BASE + `IO_IRQ_ACT_OFS): map_even = byte_t'(irq_active);
			`IO_WADDR(`IO_TIMER_BASE + `IO_TIMER_CFG_OFS): map_even = timer_regs.cfg;
			`IO_WADDR(`IO_TIMER_BASE + `IO_TIMER_CNT_OFS): map_even = timer_regs.cnt[7:0];
			`IO_WADDR(`IO_TIMER_BASE + `IO_TIMER_RLD_OFS): map_even = timer_regs.rld[7:0];
			`IO_WADDR(`IO_TIMER_BASE + `IO_TIMER_CMP_OFS): map_even = timer_regs.cmp[7:0];
			`IO_WADDR(`IO_WDOG_BASE + `IO_WDOG_CFG_OFS): map_even = wdog_regs.cfg;
			`IO_WADDR(`IO_WDOG_BASE + `IO_WDOG_CNT_OFS): map_even = wdog_regs.cnt[7:0];
			`IO_WADDR(`IO_WDOG_BASE + `IO_WDOG_RLD_OFS): map_even = wdog_regs.rld[7:0];
			`IO_WADDR(`IO_GPIO_BASE + `IO_GPIO_DDR_OFS): map_even = gpio_regs.ddr;
			`IO_WADDR(`IO_GPIO_BASE + `IO_GPIO_ODR_OFS): map_even = gpio_regs.odr;
			`IO_WADDR(`IO_GPIO_BASE + `IO_GPIO_IDR_OFS): map_even = gpio_regs.idr;
			default: map_even = 8'h00;
		endcase

		//////////////////////////////////////////////////
		// Odd bank only maps the high bytes of 16-bit registers.
		case (rd_addr_odd)
			`IO_WADDR(`IO_TIMER_BASE + `IO_TIMER_CNT_OFS): map_odd = timer_regs.cnt[15:8];
			`IO_WADDR(`IO_TIMER_BASE + `IO_TIMER_RLD_OFS): map_odd = timer_regs.rld[15:8];
			`IO_WADDR(`IO_TIMER_BASE + `IO_TIMER_CMP_OFS): map_odd = timer_regs.cmp[15:8];
			`IO_WADDR(`IO_WDOG_BASE + `IO_WDOG_CNT_OFS): map_odd = wdog_regs.cnt[15:8];
			`IO_WADDR(`IO_WDOG_BASE + `IO_WDOG_RLD_OFS): map_odd = wdog_regs.rld[15:8];
			default: map_odd = 8'h00;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_data_even <= 8'h00;
			rd_data_odd <= 8'h00;
		end
		else
		begin
			rd_data_even <= forward(wr_even, rd_addr_even, map_even);
			rd_data_odd <= forward(wr_odd, rd_addr_odd, map_odd);
		end
	end

endmodule

`default_nettype wire

// File: hw/io_gpio.sv
`timescale 1ns/10ps
`default_nettype none

module io_gpio
(
	input wire logic clk,
	input wire logic rst,
	input wire io_pkg::reg_wr_t strobes,
	input wire io_pkg::byte_t wdata_lo,
	input wire io_pkg::byte_t pins_in,
	output io_pkg::byte_t pins_out,
	output io_pkg::byte_t pins_oe,
	output io_pkg::gpio_regs_t regs
);

	// A set ddr bit turns the pin into an output.
	assign pins_out = regs.odr;
	assign pins_oe = regs.ddr;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regs <= '0;
		end
		else
		begin
			if (strobes.gpio_ddr)
				regs.ddr <= wdata_lo;
			if (strobes.gpio_odr)
				regs.odr <= wdata_lo;
			regs.idr <= pins_in; // Sampled on every edge.
		end
	end

endmodule

`default_nettype wire

// File: hw/io_irq_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module io_irq_ctrl
(
	input wire logic clk,
	input wire logic rst,
	input wire io_pkg::reg_wr_t strobes,
	input wire io_pkg::byte_t wdata_lo,
	input wire io_pkg::irq_vec_t sources,
	output io_pkg::irq_vec_t enable,
	output io_pkg::irq_vec_t active,
	output logic interrupt
);
	import io_pkg::*;

	irq_vec_t wr_bits;

	assign wr_bits = wdata_lo[$bits(irq_vec_t)-1:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			enable <= '0;
			active <= '0;
			interrupt <= 1'b0;
		end
		else
		begin
			if (strobes.irq_en)
				enable <= wr_bits;

			// Writing ones clears flags. A new source pulse beats the clear.
			active <= (strobes.irq_clr ? (active & ~wr_bits) : active) | sources;

			interrupt <= |(active & enable);
		end
	end

endmodule

`default_nettype wire

// File: hw/io_watchdog.sv
`timescale 1ns/10ps
`default_nettype none

module io_watchdog
(
	input wire logic clk,
	input wire logic rst,
	input wire io_pkg::reg_wr_t strobes,
	input wire io_pkg::word_t wdata,
	input wire logic trap,
	output io_pkg::wdog_regs_t regs,
	output logic cpu_reset
);
	import io_pkg::*;

	logic enabled;
	logic cnt_wr;
	logic expire;

	assign enabled = regs.cfg[0];
	assign cnt_wr = (strobes.wdog_cnt != 2'b00);

	// A kick or counter write in the expiring cycle holds off the reset.
	assign expire = enabled && (regs.cnt == 16'h0000) && !strobes.wdog_kick && !cnt_wr;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regs <= '0;
			cpu_reset <= 1'b0;
		end
		else
		begin
			if (strobes.wdog_cfg)
				regs.cfg <= wdata[7:0];
			regs.rld <= lane_merge(regs.rld, wdata, strobes.wdog_rld);

			if (cnt_wr)
				regs.cnt <= lane_merge(regs.cnt, wdata, strobes.wdog_cnt);
			else if (strobes.wdog_kick || expire)
				regs.cnt <= regs.rld;
			else if (enabled)
				regs.cnt <= regs.cnt - 16'd1;

			cpu_reset <= expire || trap; // One-cycle pulse to the processor.
		end
	end

endmodule

`default_nettype wire

// File: timer/io_timer.sv
`timescale 1ns/10ps
`default_nettype none

module io_timer
(
	input wire logic clk,
	input wire logic rst,
	input wire io_pkg::reg_wr_t strobes,
	input wire io_pkg::word_t wdata,
	output io_pkg::timer_regs_t regs,
	output logic ovf_irq,
	output logic cmp_irq
);
	import io_pkg::*;

	logic running;

	assign running = regs.cfg[0];

	// Both events follow the current count, so each lasts one cycle while counting.
	assign ovf_irq = running && (regs.cnt == 16'hFFFF);
	assign cmp_irq = running && (regs.cnt == regs.cmp);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regs <= '0;
		end
		else
		begin
			if (strobes.timer_cfg)
				regs.cfg <= wdata[7:0];
			regs.rld <= lane_merge(regs.rld, wdata, strobes.timer_rld);
			regs.cmp <= lane_merge(regs.cmp, wdata, strobes.timer_cmp);

			// A counter write wins over counting in the same cycle.
			if (strobes.timer_cnt != 2'b00)
				regs.cnt <= lane_merge(regs.cnt, wdata, strobes.timer_cnt);
			else if (ovf_irq)
				regs.cnt <= regs.rld; // Wrap to the reload value.
			else if (running)
				regs.cnt <= regs.cnt + 16'd1;
		end
	end

endmodule

`default_nettype wire

// File: hw/io_decode.sv
`include "io_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module io_decode
(
	input wire io_pkg::bus_wr_t wr_even,
	input wire io_pkg::bus_wr_t wr_odd,
	output io_pkg::reg_wr_t strobes
);
	import io_pkg::*;

	// A register's high byte sits at the same word address in the odd bank.
	function automatic logic hit(bus_wr_t port, logic [15:0] byte_addr);
		return port.en && (port.addr == `IO_WADDR(byte_addr));
	endfunction

	always_comb
	begin
		//////////////////////////////////////////////////
		// Timer
		strobes.timer_cfg = hit(wr_even, `IO_TIMER_BASE + `IO_TIMER_CFG_OFS);
		strobes.timer_cnt = {hit(wr_even, `IO_TIMER_BASE + `IO_TIMER_CNT_OFS),
			hit(wr_odd, `IO_TIMER_BASE + `IO_TIMER_CNT_OFS)};
		strobes.timer_rld = {hit(wr_even, `IO_TIMER_BASE + `IO_TIMER_RLD_OFS),
			hit(wr_odd, `IO_TIMER_BASE + `IO_TIMER_RLD_OFS)};
		strobes.timer_cmp = {hit(wr_even, `IO_TIMER_BASE + `IO_TIMER_CMP_OFS),
			hit(wr_odd, `IO_TIMER_BASE + `IO_TIMER_CMP_OFS)};

		//////////////////////////////////////////////////
		// Watchdog
		strobes.wdog_cfg = hit(wr_even, `IO_WDOG_BASE + `IO_WDOG_CFG_OFS);
		strobes.wdog_cnt = {hit(wr_even, `IO_WDOG_BASE + `IO_WDOG_CNT_OFS),
			hit(wr_odd, `IO_WDOG_BASE + `IO_WDOG_CNT_OFS)};
		strobes.wdog_rld = {hit(wr_even, `IO_WDOG_BASE + `IO_WDOG_RLD_OFS),
			hit(wr_odd, `IO_WDOG_BASE + `IO_WDOG_RLD_OFS)};
		strobes.wdog_kick = hit(wr_even, `IO_KICK_ADDR); // Any byte value kicks.

		//////////////////////////////////////////////////
		// Interrupt controller and GPIO, even bank only.
		strobes.irq_en = hit(wr_even, `IO_IRQ_BASE + `IO_IRQ_EN_OFS);
		strobes.irq_clr = hit(wr_even, `IO_IRQ_BASE + `IO_IRQ_ACT_OFS);
		strobes.gpio_ddr = hit(wr_even, `IO_GPIO_BASE + `IO_GPIO_DDR_OFS);
		strobes.gpio_odr = hit(wr_even, `IO_GPIO_BASE + `IO_GPIO_ODR_OFS);
	end

endmodule

`default_nettype wire

// File: common/io_pkg.sv
`include "io_settings.svh"
`default_nettype none

package io_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [14:0] waddr_t;
	typedef logic [`IO_NUM_IRQ-1:0] irq_vec_t;

	// One bank's write port.
	typedef struct packed
	{
		waddr_t addr;
		byte_t data;
		logic en;
	} bus_wr_t;

	// Lane masks carry the even (low) byte in bit 1 and the odd (high) byte in bit 0.
	typedef struct packed
	{
		logic timer_cfg;
		logic [1:0] timer_cnt;
		logic [1:0] timer_rld;
		logic [1:0] timer_cmp;
		logic wdog_cfg;
		logic [1:0] wdog_cnt;
		logic [1:0] wdog_rld;
		logic wdog_kick;
		logic irq_en;
		logic irq_clr;
		logic gpio_ddr;
		logic gpio_odr;
	} reg_wr_t;

	typedef struct packed
	{
		byte_t cfg;
		word_t cnt;
		word_t rld;
		word_t cmp;
	} timer_regs_t;

	typedef struct packed
	{
		byte_t cfg;
		word_t cnt;
		word_t rld;
	} wdog_regs_t;

	typedef struct packed
	{
		byte_t ddr;
		byte_t odr;
		byte_t idr;
	} gpio_regs_t;

	function automatic word_t lane_merge(word_t old, word_t wdata, logic [1:0] lanes);
		word_t res;
		res = old;
		if (lanes[1])
			res[7:0] = wdata[7:0];
		if (lanes[0])
			res[15:8] = wdata[15:8];
		return res;
	endfunction

endpackage

`default_nettype wire

// File: common/io_settings.svh
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH
`default_nettype none

`define IO_NUM_IRQ 2

// Block base addresses in the 16-bit byte address space.
`define IO_IRQ_BASE   16'h0010
`define IO_TIMER_BASE 16'h0018
`define IO_WDOG_BASE  16'h0020
`define IO_GPIO_BASE  16'h0028
`define IO_KICK_ADDR  16'h0000

// Register offsets within each block.
`define IO_IRQ_EN_OFS     16'd0
`define IO_IRQ_ACT_OFS    16'd2
`define IO_TIMER_CFG_OFS  16'd0
`define IO_TIMER_CNT_OFS  16'd2
`define IO_TIMER_RLD_OFS  16'd4
`define IO_TIMER_CMP_OFS  16'd6
`define IO_WDOG_CFG_OFS   16'd0
`define IO_WDOG_CNT_OFS   16'd2
`define IO_WDOG_RLD_OFS   16'd4
`define IO_GPIO_DDR_OFS   16'd0
`define IO_GPIO_ODR_OFS   16'd2
`define IO_GPIO_IDR_OFS   16'd4

// Bank word address of a byte address. Both bytes of a 16-bit register share it.
`define IO_WADDR(a) (15'((a) >> 1))

`default_nettype wire
`endif
